// File: tb.f
+incdir+tb
rtl/risc_io_pkg.sv
rtl/tmr.sv
rtl/bio.sv
rtl/io_decode.sv
rtl/io_sys.sv
tb/io_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the io_sys testbench with Verilator, run it and check sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module io_tb -f tb.f -Mdir obj_dir -o io_tb \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/io_tb > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -qx "Everything OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb/io_model.svh
// reference model of the I/O devices, included inside the io_tb module
// predicts device selection, hex glyphs, read words and timer tick spans

`ifndef IO_MODEL_SVH
`define IO_MODEL_SVH

// word address of a device slot inside the I/O window
function automatic logic [21:0] window_addr(input logic [3:0] ofs);
  return {risc_io_pkg::IO_WIN_HI, ofs};
endfunction

// which device a word address reaches, per the memory map
function automatic risc_io_pkg::io_dev_e classify_addr(input logic [21:0] waddr);
  if (waddr[21:4] != risc_io_pkg::IO_WIN_HI) begin
    return risc_io_pkg::DEV_NONE;            // outside the top 64 bytes
  end
  if (waddr[3:0] == risc_io_pkg::TMR_OFS) begin
    return risc_io_pkg::DEV_TMR;
  end
  if (waddr[3:0] == risc_io_pkg::BIO_OFS) begin
    return risc_io_pkg::DEV_BIO;
  end
  return risc_io_pkg::DEV_NONE;              // unused slot
endfunction

// standard hex glyph, built active high and then inverted for the board
function automatic logic [6:0] glyph_n(input logic [3:0] nib);
  logic [6:0] lit;                           // bit 0 is segment a
  case (nib)
    4'h0: lit = 7'h3F;
    4'h1: lit = 7'h06;
    4'h2: lit = 7'h5B;
    4'h3: lit = 7'h4F;
    4'h4: lit = 7'h66;
    4'h5: lit = 7'h6D;
    4'h6: lit = 7'h7D;
    4'h7: lit = 7'h07;
    4'h8: lit = 7'h7F;
    4'h9: lit = 7'h6F;
    4'hA: lit = 7'h77;
    4'hB: lit = 7'h7C;
    4'hC: lit = 7'h39;
    4'hD: lit = 7'h5E;
    4'hE: lit = 7'h79;
    default: lit = 7'h71;
  endcase
  return ~lit;
endfunction

// board I/O read word for steady switches and keys
function automatic logic [31:0] expect_read_word(input logic [15:0] sw_in,
                                                 input logic [2:0]  key_in_n);
  logic [31:0] word;
  word        = '0;
  word[15:0]  = sw_in;
  word[18:16] = ~key_in_n;                   // keys read active high
  return word;
endfunction

// count change over n_cyc clocks is floor(n_cyc / TICK_DIV) or one more
function automatic logic tick_span_ok(input logic [31:0] first, input logic [31:0] second,
                                      input logic [31:0] n_cyc);
  logic [31:0] diff;
  logic [31:0] lo;
  diff = second - first;
  lo   = n_cyc / {16'd0, risc_io_pkg::TICK_DIV};
  return (diff == lo) || (diff == lo + 32'd1);
endfunction

`endif

// File: tb/io_tb.sv
// testbench for io_sys with random bus traffic checked against io_model.svh
// compiled through tb.f and ends with an error count and one pass or fail line

module io_tb;

  localparam int unsigned N_ACC       = 400;  // bus accesses in the random run
  localparam int unsigned CYC_PER_ACC = 8;
  localparam int unsigned IDLE_MAX    = 63;   // idle cycles between timer reads
  localparam int unsigned RST_CYC     = 10;
  localparam int unsigned ACK_WAIT    = 4;    // cycles one access may wait
  localparam int unsigned CYC_LIMIT   = N_ACC * (CYC_PER_ACC + IDLE_MAX) + RST_CYC + 100;

  logic                            clk;
  logic                            rst_n;
  risc_io_pkg::bus_req_t           bus_req;
  risc_io_pkg::bus_rsp_t           bus_rsp;
  logic [risc_io_pkg::LED_W-1:0]   led;
  logic [6:0]                      hex3_n;
  logic [6:0]                      hex2_n;
  logic [6:0]                      hex1_n;
  logic [6:0]                      hex0_n;
  logic [2:0]                      key_n;
  logic [risc_io_pkg::SW_W-1:0]    sw;

  integer      seed;
  int unsigned cyc;                           // rising edges since start
  int unsigned errors;
  int unsigned checks;
  int unsigned n_acc;
  int unsigned ack_cyc;                       // cyc when the last ack was seen
  logic [15:0] led_exp;                       // model of the LED register

  `include "io_model.svh"

  io_sys dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .led     (led),
    .hex3_n  (hex3_n),
    .hex2_n  (hex2_n),
    .hex1_n  (hex1_n),
    .hex0_n  (hex0_n),
    .key_n   (key_n),
    .sw      (sw)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // watchdog
  initial begin
    cyc = 0;
    while (cyc < CYC_LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout: test did not finish within %0d clock cycles", CYC_LIMIT);
    $display("errors: %0d, checks: %0d", errors, checks);
    $display("Something failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic expect_true(input logic ok, input string what);
    checks++;
    assert (ok === 1'b1) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  // LEDs and all four digits against the model
  task automatic check_board();
    compare_value("led", 32'(led), 32'(led_exp));
    compare_value("hex0_n", 32'(hex0_n), 32'(glyph_n(led_exp[3:0])));
    compare_value("hex1_n", 32'(hex1_n), 32'(glyph_n(led_exp[7:4])));
    compare_value("hex2_n", 32'(hex2_n), 32'(glyph_n(led_exp[11:8])));
    compare_value("hex3_n", 32'(hex3_n), 32'(glyph_n(led_exp[15:12])));
  endtask

  // --------------------------------------------------------------------------
  // bus master task entered on a falling edge
  // --------------------------------------------------------------------------

  task automatic bus_access(input logic we, input logic [21:0] waddr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int unsigned waited;
    logic        acked;
    bus_req.stb   = 1'b1;
    bus_req.we    = we;
    bus_req.addr  = waddr;
    bus_req.wdata = wdata;
    waited        = 0;
    acked         = 1'b0;
    rdata         = '0;
    while (!acked && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
      if (bus_rsp.ack) begin
        acked   = 1'b1;
        rdata   = bus_rsp.rdata;
        ack_cyc = cyc;
      end
    end
    check_board();                           // a write shows on its ack edge
    bus_req.stb = 1'b0;                      // dropped before the next edge
    n_acc++;
    expect_true(acked, $sformatf("no acknowledge for word address %h", waddr));
    expect_true(waited == 1, $sformatf("acknowledge late for word address %h", waddr));
    @(negedge clk);
    expect_true(!bus_rsp.ack, "acknowledge held for more than one cycle");
    compare_value("bus_rsp.rdata", bus_rsp.rdata, 32'd0);   // idle bus
  endtask

  // --------------------------------------------------------------------------
  // test steps
  // --------------------------------------------------------------------------

  task automatic bio_write_test();
    logic [31:0] wdata;
    logic [31:0] rdata;
    wdata   = $random(seed);
    led_exp = wdata[15:0];                   // LEDs follow on the ack edge
    bus_access(1'b1, window_addr(risc_io_pkg::BIO_OFS), wdata, rdata);
  endtask

  task automatic bio_read_test();
    logic [31:0] r;
    logic [31:0] rdata;
    r     = $random(seed);
    sw    = r[15:0];
    key_n = r[18:16];
    repeat (4) @(negedge clk);               // past both sync stages
    bus_access(1'b0, window_addr(risc_io_pkg::BIO_OFS), r, rdata);
    compare_value("bus_rsp.rdata", rdata, expect_read_word(sw, key_n));
  endtask

  task automatic timer_span_test();
    logic [31:0] r;
    logic [31:0] t0;
    logic [31:0] t1;
    int unsigned c0;
    int unsigned idle;
    r    = $random(seed);
    idle = r % (IDLE_MAX + 1);
    bus_access(1'b0, window_addr(risc_io_pkg::TMR_OFS), r, t0);
    c0 = ack_cyc;
    repeat (idle) @(negedge clk);
    bus_access(1'b0, window_addr(risc_io_pkg::TMR_OFS), r, t1);
    expect_true(tick_span_ok(t0, t1, ack_cyc - c0),
                $sformatf("timer moved %0d ticks over %0d cycles", t1 - t0, ack_cyc - c0));
  endtask

  task automatic timer_write_test();
    logic [31:0] wdata;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] rdata;
    int unsigned c0;
    wdata = $random(seed);
    bus_access(1'b0, window_addr(risc_io_pkg::TMR_OFS), wdata, t0);
    c0 = ack_cyc;
    bus_access(1'b1, window_addr(risc_io_pkg::TMR_OFS), wdata, rdata);
    bus_access(1'b0, window_addr(risc_io_pkg::TMR_OFS), wdata, t1);
    expect_true(tick_span_ok(t0, t1, ack_cyc - c0),
                $sformatf("timer moved %0d ticks across a write", t1 - t0));
  endtask

  task automatic unmapped_test();
    logic [31:0] r;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [21:0] waddr;
    r     = $random(seed);
    wdata = $random(seed);
    if (r[0]) begin
      waddr = window_addr(4'((r >> 4) % 32'd14) + 4'd2);   // slots 2 to 15
    end else begin
      waddr = r[31:10];
      if (classify_addr(waddr) != risc_io_pkg::DEV_NONE) begin
        waddr[21] = 1'b0;                    // push it out of the window
      end
    end
    bus_access(r[1], waddr, wdata, rdata);
    compare_value("bus_rsp.rdata", rdata, 32'd0);
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------

  initial begin
    logic [31:0] r;
    seed    = 65;
    errors  = 0;
    checks  = 0;
    n_acc   = 0;
    ack_cyc = 0;
    led_exp = '0;
    rst_n   = 1'b0;
    bus_req = '0;
    key_n   = 3'b111;                        // keys released
    sw      = '0;
    repeat (RST_CYC) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    expect_true(!bus_rsp.ack, "acknowledge high after reset");
    check_board();

    while (n_acc < N_ACC) begin
      r = $random(seed);
      case (r % 32'd5)
        32'd0: bio_write_test();
        32'd1: bio_read_test();
        32'd2: timer_span_test();
        32'd3: timer_write_test();
        default: unmapped_test();
      endcase
    end

    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: rtl/io_sys.sv
// I/O end of the RISC bus: decoder, millisecond timer and board I/O
// the external master drives bus_req and waits for bus_rsp.ack

module io_sys (
  input  logic                             clk,
  input  logic                             rst_n,
  input  risc_io_pkg::bus_req_t            bus_req,
  output risc_io_pkg::bus_rsp_t            bus_rsp,
  output logic [risc_io_pkg::LED_W-1:0]    led,
  output logic [6:0]                       hex3_n,
  output logic [6:0]                       hex2_n,
  output logic [6:0]                       hex1_n,
  output logic [6:0]                       hex0_n,
  input  logic [2:0]                       key_n,
  input  logic [risc_io_pkg::SW_W-1:0]     sw
);

  risc_io_pkg::bus_req_t tmr_req;            // timer side
  risc_io_pkg::bus_rsp_t tmr_rsp;
  risc_io_pkg::bus_req_t bio_req;            // board I/O side
  risc_io_pkg::bus_rsp_t bio_rsp;

  // --------------------------------------------------------------------------
  // module instances
  // --------------------------------------------------------------------------

  io_decode io_decode_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .tmr_req (tmr_req),
    .tmr_rsp (tmr_rsp),
    .bio_req (bio_req),
    .bio_rsp (bio_rsp)
  );

  tmr tmr_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (tmr_req),
    .rsp   (tmr_rsp)
  );

  bio bio_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (bio_req),
    .rsp    (bio_rsp),
    .led    (led),
    .hex3_n (hex3_n),
    .hex2_n (hex2_n),
    .hex1_n (hex1_n),
    .hex0_n (hex0_n),
    .key_n  (key_n),
    .sw     (sw)
  );

endmodule

// File: rtl/io_decode.sv
// address decoder for the I/O window at 0xFFFFC0
// routes the strobe to timer or board I/O and muxes the response back

module io_decode (
  input  logic                  clk,
  input  logic                  rst_n,
  input  risc_io_pkg::bus_req_t bus_req,
  output risc_io_pkg::bus_rsp_t bus_rsp,
  output risc_io_pkg::bus_req_t tmr_req,
  input  risc_io_pkg::bus_rsp_t tmr_rsp,
  output risc_io_pkg::bus_req_t bio_req,
  input  risc_io_pkg::bus_rsp_t bio_rsp
);

  risc_io_pkg::io_dev_e dev;                 // current selection
  logic                 in_win;
  logic                 none_ack_q;          // ack for unmapped accesses

  // --------------------------------------------------------------------------
  // address classification
  // --------------------------------------------------------------------------

  assign in_win = (bus_req.addr[23:6] == risc_io_pkg::IO_WIN_HI);

  always_comb begin
    dev = risc_io_pkg::DEV_NONE;
    if (in_win) begin
      if (bus_req.addr[5:2] == risc_io_pkg::TMR_OFS) begin
        dev = risc_io_pkg::DEV_TMR;
      end else if (bus_req.addr[5:2] == risc_io_pkg::BIO_OFS) begin
        dev = risc_io_pkg::DEV_BIO;
      end
    end
  end

  // --------------------------------------------------------------------------
  // per-device requests
  // --------------------------------------------------------------------------

  // same request everywhere, only the strobe is gated
  always_comb begin
    tmr_req     = bus_req;
    tmr_req.stb = bus_req.stb && (dev == risc_io_pkg::DEV_TMR);
    bio_req     = bus_req;
    bio_req.stb = bus_req.stb && (dev == risc_io_pkg::DEV_BIO);
  end

  // unmapped address gets an ack with zero data instead of hanging
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      none_ack_q <= 1'b0;
    end else begin
      none_ack_q <= bus_req.stb && (dev == risc_io_pkg::DEV_NONE) && !none_ack_q;
    end
  end

  // --------------------------------------------------------------------------
  // response mux
  // --------------------------------------------------------------------------

  // selection stays put for the whole access, the master holds addr
  always_comb begin
    case (dev)
      risc_io_pkg::DEV_TMR: begin
        bus_rsp = tmr_rsp;
      end
      risc_io_pkg::DEV_BIO: begin
        bus_rsp = bio_rsp;
      end
      default: begin
        bus_rsp.ack   = none_ack_q;
        bus_rsp.rdata = '0;
      end
    endcase
  end

endmodule

// File: rtl/bio.sv
// board I/O block: LED register, four hex digits, switch and key read port
// writes set the LEDs, reads return synchronized switches and keys

module bio (
  input  logic                               clk,
  input  logic                               rst_n,
  input  risc_io_pkg::bus_req_t              req,
  output risc_io_pkg::bus_rsp_t              rsp,
  output logic [risc_io_pkg::LED_W-1:0]      led,
  output logic [6:0]                         hex3_n,
  output logic [6:0]                         hex2_n,
  output logic [6:0]                         hex1_n,
  output logic [6:0]                         hex0_n,
  input  logic [2:0]                         key_n,
  input  logic [risc_io_pkg::SW_W-1:0]       sw
);

  // switches and keys move through the synchronizer together
  typedef struct packed {
    logic [2:0]                   key_n;
    logic [risc_io_pkg::SW_W-1:0] sw;
  } board_in_t;

  logic [risc_io_pkg::LED_W-1:0] led_q;
  board_in_t                     in_s1;      // first sync stage
  board_in_t                     in_s2;      // second sync stage, safe to read
  logic                          ack_q;
  logic [31:0]                   rdata_q;

  // active-low glyphs, bit 0 is segment a
  function automatic logic [6:0] seg7_n(input logic [3:0] nib);
    logic [6:0] seg;
    case (nib)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'hA: seg = 7'b0001000;
      4'hB: seg = 7'b0000011;                // lower case b
      4'hC: seg = 7'b1000110;
      4'hD: seg = 7'b0100001;                // lower case d
      4'hE: seg = 7'b0000110;
      default: seg = 7'b0001110;             // F
    endcase
    return seg;
  endfunction

  // --------------------------------------------------------------------------
  // bus port
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req.stb && !ack_q;
    end
  end

  // LEDs change on the same edge that acks the write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led_q <= '0;
    end else if (req.stb && !ack_q && req.we) begin
      led_q <= req.wdata[risc_io_pkg::LED_W-1:0];
    end
  end

  // read word: keys active high in 18:16, switches in 15:0
  always_ff @(posedge clk) begin
    if (req.stb && !ack_q && !req.we) begin
      rdata_q <= {13'd0, ~in_s2.key_n, in_s2.sw};
    end else begin
      rdata_q <= '0;
    end
  end

  assign rsp.ack   = ack_q;
  assign rsp.rdata = rdata_q;

  // --------------------------------------------------------------------------
  // board side
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    in_s1 <= '{key_n: key_n, sw: sw};
    in_s2 <= in_s1;
  end

  assign led    = led_q;
  assign hex0_n = seg7_n(led_q[3:0]);        // lowest nibble
  assign hex1_n = seg7_n(led_q[7:4]);
  assign hex2_n = seg7_n(led_q[11:8]);
  assign hex3_n = seg7_n(led_q[15:12]);

endmodule

// File: rtl/tmr.sv
// millisecond timer on the I/O bus
// free-running tick counter behind a prescaler, read-only from the bus

module tmr (
  input  logic                  clk,
  input  logic                  rst_n,
  input  risc_io_pkg::bus_req_t req,
  output risc_io_pkg::bus_rsp_t rsp
);

  logic [15:0] pre_q;                        // prescaler, wraps at TICK_DIV
  logic [31:0] cnt_q;                        // tick count
  logic        tick;
  logic        ack_q;
  logic [31:0] rdata_q;

  // --------------------------------------------------------------------------
  // prescaler and tick counter
  // --------------------------------------------------------------------------

  assign tick = (pre_q == risc_io_pkg::TICK_DIV - 16'd1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pre_q <= '0;
    end else if (tick) begin
      pre_q <= '0;
    end else begin
      pre_q <= pre_q + 16'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (tick) begin
      cnt_q <= cnt_q + 32'd1;                // wraps freely
    end
  end

  // --------------------------------------------------------------------------
  // bus port
  // --------------------------------------------------------------------------

  // one-cycle ack, the edge after stb is first seen
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req.stb && !ack_q;
    end
  end

  // count captured on the ack edge, zero outside a read
  always_ff @(posedge clk) begin
    if (req.stb && !ack_q && !req.we) begin
      rdata_q <= cnt_q;
    end else begin
      rdata_q <= '0;                         // writes are ignored
    end
  end

  assign rsp.ack   = ack_q;
  assign rsp.rdata = rdata_q;

endmodule

// File: rtl/risc_io_pkg.sv
// shared types and constants for the RISC I/O window
// every RTL file refers to these by scoped name

package risc_io_pkg;

  // --------------------------------------------------------------------------
  // address map
  // --------------------------------------------------------------------------

  // byte address bits 23:6 of the 64-byte I/O window at 0xFFFFC0
  localparam logic [17:0] IO_WIN_HI = 18'h3FFFF;

  localparam logic [3:0] TMR_OFS = 4'd0;     // word offset of the timer
  localparam logic [3:0] BIO_OFS = 4'd1;     // word offset of board I/O

  // --------------------------------------------------------------------------
  // timing and board widths
  // --------------------------------------------------------------------------

  // clocks per timer tick, scaled down for simulation
  localparam logic [15:0] TICK_DIV = 16'd50;

  localparam int unsigned LED_W = 16;        // LEDs, also four hex nibbles
  localparam int unsigned SW_W  = 16;        // slide switches

  // --------------------------------------------------------------------------
  // bus types
  // --------------------------------------------------------------------------

  // one request from the master, held steady until ack
  typedef struct packed {
    logic        stb;
    logic        we;
    logic [23:2] addr;                       // word address, byte bits 23:2
    logic [31:0] wdata;
  } bus_req_t;

  // one response, rdata is zero whenever ack is low
  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } bus_rsp_t;

  // device chosen by the address decoder
  typedef enum logic [1:0] {
    DEV_NONE,                                // outside window or unused offset
    DEV_TMR,
    DEV_BIO
  } io_dev_e;

endpackage
